//--- decode_pkg.sv
package decode_pkg;

    // datapath width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes, inst[6:2] only
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_FENCE  = 5'b00011;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // funct7 patterns
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // shift funct3, shared by classifier and immediate mux
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR  = 3'b101;

    // system imm field for ecall / ebreak
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;

    // the six instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        FU_NONE,
        FU_ALU,
        FU_MDU,
        FU_LDU,
        FU_STU,
        FU_BJU,
        FU_SCU
    } fu_e;

    // micro-op, meaning depends on fu
    typedef logic [3:0] micop_t;

    // alu
    localparam micop_t MICOP_ADD  = 4'd0;
    localparam micop_t MICOP_SUB  = 4'd1;
    localparam micop_t MICOP_SLL  = 4'd2;
    localparam micop_t MICOP_SLT  = 4'd3;
    localparam micop_t MICOP_SLTU = 4'd4;
    localparam micop_t MICOP_XOR  = 4'd5;
    localparam micop_t MICOP_SRL  = 4'd6;
    localparam micop_t MICOP_SRA  = 4'd7;
    localparam micop_t MICOP_OR   = 4'd8;
    localparam micop_t MICOP_AND  = 4'd9;
    localparam micop_t MICOP_LUI  = 4'd10;
    // mdu, funct3 order
    localparam micop_t MICOP_MUL    = 4'd0;
    localparam micop_t MICOP_MULH   = 4'd1;
    localparam micop_t MICOP_MULHSU = 4'd2;
    localparam micop_t MICOP_MULHU  = 4'd3;
    localparam micop_t MICOP_DIV    = 4'd4;
    localparam micop_t MICOP_DIVU   = 4'd5;
    localparam micop_t MICOP_REM    = 4'd6;
    localparam micop_t MICOP_REMU   = 4'd7;
    // ldu / stu, funct3 order
    localparam micop_t MICOP_LB  = 4'd0;
    localparam micop_t MICOP_LH  = 4'd1;
    localparam micop_t MICOP_LW  = 4'd2;
    localparam micop_t MICOP_LBU = 4'd4;
    localparam micop_t MICOP_LHU = 4'd5;
    localparam micop_t MICOP_SB  = 4'd0;
    localparam micop_t MICOP_SH  = 4'd1;
    localparam micop_t MICOP_SW  = 4'd2;
    // bju
    localparam micop_t MICOP_JAL  = 4'd0;
    localparam micop_t MICOP_JALR = 4'd1;
    localparam micop_t MICOP_BEQ  = 4'd2;
    localparam micop_t MICOP_BNE  = 4'd3;
    localparam micop_t MICOP_BLT  = 4'd4;
    localparam micop_t MICOP_BGE  = 4'd5;
    localparam micop_t MICOP_BLTU = 4'd6;
    localparam micop_t MICOP_BGEU = 4'd7;
    // scu, bit 3 marks the csr imm forms
    localparam micop_t MICOP_ECALL  = 4'd0;
    localparam micop_t MICOP_EBREAK = 4'd1;
    localparam micop_t MICOP_FENCE  = 4'd2;
    localparam micop_t MICOP_FENCEI = 4'd3;
    localparam micop_t MICOP_CSRRW  = 4'd4;
    localparam micop_t MICOP_CSRRS  = 4'd5;
    localparam micop_t MICOP_CSRRC  = 4'd6;
    localparam micop_t MICOP_CSRRWI = 4'd12;
    localparam micop_t MICOP_CSRRSI = 4'd13;
    localparam micop_t MICOP_CSRRCI = 4'd14;

    // classifier result
    typedef struct packed {
        fu_e      fu;
        micop_t   micop;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     rd_en;
        logic     rs1_en;
        logic     rs2_en;
        logic     rs1topc;
        logic     rs2toimm;
        logic     is_nop;
        logic     illegal;
    } dec_ctrl_t;

    // record handed to the next stage
    typedef struct packed {
        dec_ctrl_t ctrl;
        word_t     imm;
        word_t     pc;
    } decinfo_t;

endpackage

//--- inst_classify.sv
`timescale 1ns/1ps

module inst_classify import decode_pkg::*; (
    input  inst_u     i_inst,
    output dec_ctrl_t o_ctrl
);

    // fields shared by most formats
    logic [4:0]  opc;
    logic [2:0]  fn3;
    logic [6:0]  fn7;
    logic [11:0] imm12;
    logic        is_32b;

    // per-opcode decode
    fu_e    fu;
    micop_t micop;
    logic   use_rd;
    logic   use_rs1;
    logic   use_rs2;
    logic   known;
    logic   legal;

    // alu op from funct3, alt picks sub / sra
    function automatic micop_t alu_micop(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? MICOP_SUB : MICOP_ADD;
            3'b001:  return MICOP_SLL;
            3'b010:  return MICOP_SLT;
            3'b011:  return MICOP_SLTU;
            3'b100:  return MICOP_XOR;
            3'b101:  return alt ? MICOP_SRA : MICOP_SRL;
            3'b110:  return MICOP_OR;
            default: return MICOP_AND;
        endcase
    endfunction

    assign opc    = i_inst.r_fmt.opcode[6:2];
    assign fn3    = i_inst.r_fmt.funct3;
    assign fn7    = i_inst.r_fmt.funct7;
    assign imm12  = i_inst.i_fmt.imm_11_0;
    // compressed words have low bits != 11
    assign is_32b = (i_inst.r_fmt.opcode[1:0] == 2'b11);

    always_comb begin
        fu      = FU_NONE;
        micop   = MICOP_ADD;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        known   = 1'b1;
        case (opc)
            OPC_LUI: begin
                fu     = FU_ALU;
                micop  = MICOP_LUI;
                use_rd = 1'b1;
            end
            // pc + imm through the alu adder
            OPC_AUIPC: begin
                fu     = FU_ALU;
                micop  = MICOP_ADD;
                use_rd = 1'b1;
            end
            OPC_JAL: begin
                fu     = FU_BJU;
                micop  = MICOP_JAL;
                use_rd = 1'b1;
            end
            OPC_JALR: begin
                fu      = FU_BJU;
                micop   = MICOP_JALR;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                known   = (fn3 == 3'b000);
            end
            OPC_BRANCH: begin
                fu      = FU_BJU;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (fn3)
                    3'b000:  micop = MICOP_BEQ;
                    3'b001:  micop = MICOP_BNE;
                    3'b100:  micop = MICOP_BLT;
                    3'b101:  micop = MICOP_BGE;
                    3'b110:  micop = MICOP_BLTU;
                    3'b111:  micop = MICOP_BGEU;
                    default: known = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                fu      = FU_LDU;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                case (fn3)
                    3'b000:  micop = MICOP_LB;
                    3'b001:  micop = MICOP_LH;
                    3'b010:  micop = MICOP_LW;
                    3'b100:  micop = MICOP_LBU;
                    3'b101:  micop = MICOP_LHU;
                    default: known = 1'b0;
                endcase
            end
            OPC_STORE: begin
                fu      = FU_STU;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (fn3)
                    3'b000:  micop = MICOP_SB;
                    3'b001:  micop = MICOP_SH;
                    3'b010:  micop = MICOP_SW;
                    default: known = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                fu      = FU_ALU;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                micop   = alu_micop(fn3, (fn3 == F3_SR) && (fn7 == F7_ALT));
                // shifts keep funct7 in the imm field
                if (fn3 == F3_SLL) begin
                    known = (fn7 == F7_BASE);
                end else if (fn3 == F3_SR) begin
                    known = (fn7 == F7_BASE) || (fn7 == F7_ALT);
                end
            end
            OPC_OP: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (fn7 == F7_MULDIV) begin
                    fu = FU_MDU;
                    case (fn3)
                        3'b000:  micop = MICOP_MUL;
                        3'b001:  micop = MICOP_MULH;
                        3'b010:  micop = MICOP_MULHSU;
                        3'b011:  micop = MICOP_MULHU;
                        3'b100:  micop = MICOP_DIV;
                        3'b101:  micop = MICOP_DIVU;
                        3'b110:  micop = MICOP_REM;
                        default: micop = MICOP_REMU;
                    endcase
                end else begin
                    fu    = FU_ALU;
                    micop = alu_micop(fn3, fn7 == F7_ALT);
                    // alt form only exists for sub and sra
                    known = (fn7 == F7_BASE) ||
                            ((fn7 == F7_ALT) && ((fn3 == 3'b000) || (fn3 == F3_SR)));
                end
            end
            OPC_FENCE: begin
                fu = FU_SCU;
                case (fn3)
                    3'b000:  micop = MICOP_FENCE;
                    3'b001:  micop = MICOP_FENCEI;
                    default: known = 1'b0;
                endcase
            end
            OPC_SYSTEM: begin
                fu = FU_SCU;
                case (fn3)
                    3'b000: begin
                        if (imm12 == F12_ECALL) begin
                            micop = MICOP_ECALL;
                        end else if (imm12 == F12_EBREAK) begin
                            micop = MICOP_EBREAK;
                        end else begin
                            known = 1'b0;
                        end
                    end
                    3'b001:  micop = MICOP_CSRRW;
                    3'b010:  micop = MICOP_CSRRS;
                    3'b011:  micop = MICOP_CSRRC;
                    3'b101:  micop = MICOP_CSRRWI;
                    3'b110:  micop = MICOP_CSRRSI;
                    3'b111:  micop = MICOP_CSRRCI;
                    default: known = 1'b0;
                endcase
                // rs1 slot holds zimm in the imm forms
                use_rd  = (fn3 != 3'b000);
                use_rs1 = (fn3 != 3'b000) && !fn3[2];
            end
            default: known = 1'b0;
        endcase
    end

    assign legal = known && is_32b;

    always_comb begin
        o_ctrl.fu       = legal ? fu : FU_NONE;
        o_ctrl.micop    = legal ? micop : MICOP_ADD;
        o_ctrl.rd       = i_inst.r_fmt.rd;
        o_ctrl.rs1      = i_inst.r_fmt.rs1;
        o_ctrl.rs2      = i_inst.r_fmt.rs2;
        // x0 never read or written
        o_ctrl.rd_en    = legal && use_rd && (i_inst.r_fmt.rd != '0);
        o_ctrl.rs1_en   = legal && use_rs1 && (i_inst.r_fmt.rs1 != '0);
        o_ctrl.rs2_en   = legal && use_rs2 && (i_inst.r_fmt.rs2 != '0);
        o_ctrl.rs1topc  = legal && ((opc == OPC_AUIPC) || (opc == OPC_JAL));
        o_ctrl.rs2toimm = legal && ((opc == OPC_LUI) || (opc == OPC_AUIPC) ||
                          (opc == OPC_OPIMM) || (opc == OPC_LOAD) || (opc == OPC_STORE));
        // addi rX, rX, 0 does nothing
        o_ctrl.is_nop   = legal && (opc == OPC_OPIMM) && (fn3 == 3'b000) &&
                          (i_inst.r_fmt.rd == i_inst.r_fmt.rs1) && (imm12 == '0);
        o_ctrl.illegal  = !legal;
    end

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  inst_u i_inst,
    output word_t o_imm
);

    logic [4:0] opc;
    logic [2:0] fn3;

    // one candidate per format
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_sh;
    word_t imm_z;

    assign opc = i_inst.r_fmt.opcode[6:2];
    assign fn3 = i_inst.r_fmt.funct3;

    // jalr, load, op-imm
    assign imm_i = {{20{i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};

    // store, split 7 + 5
    assign imm_s = {{20{i_inst.s_fmt.imm_11_5[6]}},
                    i_inst.s_fmt.imm_11_5,
                    i_inst.s_fmt.imm_4_0};

    // branch offset, bit 0 always zero
    assign imm_b = {{19{i_inst.b_fmt.imm_12}},
                    i_inst.b_fmt.imm_12,
                    i_inst.b_fmt.imm_11,
                    i_inst.b_fmt.imm_10_5,
                    i_inst.b_fmt.imm_4_1,
                    1'b0};

    // upper 20 bits, low 12 cleared
    assign imm_u = {i_inst.u_fmt.imm_31_12, 12'b0};

    // jal offset
    assign imm_j = {{11{i_inst.j_fmt.imm_20}},
                    i_inst.j_fmt.imm_20,
                    i_inst.j_fmt.imm_19_12,
                    i_inst.j_fmt.imm_11,
                    i_inst.j_fmt.imm_10_1,
                    1'b0};

    // shamt sits in the rs2 slot, zimm in the rs1 slot
    assign imm_sh = {27'b0, i_inst.r_fmt.rs2};
    assign imm_z  = {27'b0, i_inst.i_fmt.rs1};

    always_comb begin
        case (opc)
            OPC_LUI,
            OPC_AUIPC:  o_imm = imm_u;
            OPC_JAL:    o_imm = imm_j;
            OPC_BRANCH: o_imm = imm_b;
            OPC_STORE:  o_imm = imm_s;
            OPC_JALR,
            OPC_LOAD:   o_imm = imm_i;
            OPC_OPIMM:  o_imm = ((fn3 == F3_SLL) || (fn3 == F3_SR)) ? imm_sh : imm_i;
            // only the csr imm forms carry one
            OPC_SYSTEM: o_imm = fn3[2] ? imm_z : '0;
            default:    o_imm = '0;
        endcase
    end

endmodule

//--- decinfo_pack.sv
`timescale 1ns/1ps

module decinfo_pack import decode_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,

    // upstream channel
    input  logic      i_inst_valid,
    output logic      o_inst_ready,
    input  word_t     i_pc,

    // from classifier and immediate generator
    input  dec_ctrl_t i_ctrl,
    input  word_t     i_imm,

    // downstream channel
    output logic      o_dec_valid,
    input  logic      i_dec_ready,
    output decinfo_t  o_decinfo
);

    // one-entry output register
    logic     dec_valid_q;
    decinfo_t decinfo_q;

    decinfo_t rec_d;
    logic     inst_fire;

    // merged record for this word
    assign rec_d = '{ctrl: i_ctrl, imm: i_imm, pc: i_pc};

    // free slot, or the held record leaves on this edge
    assign o_inst_ready = !dec_valid_q || i_dec_ready;
    assign inst_fire    = i_inst_valid && o_inst_ready;

    // valid follows the input whenever the slot turns over
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dec_valid_q <= 1'b0;
        end else if (o_inst_ready) begin
            dec_valid_q <= i_inst_valid;
        end
    end

    // payload, loaded only on a transfer
    always_ff @(posedge clk) begin
        if (inst_fire) begin
            decinfo_q <= rec_d;
        end
    end

    assign o_dec_valid = dec_valid_q;
    assign o_decinfo   = decinfo_q;

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,

    // instruction in
    input  logic     i_inst_valid,
    output logic     o_inst_ready,
    input  inst_u    i_inst,
    input  word_t    i_pc,

    // decode record out
    output logic     o_dec_valid,
    input  logic     i_dec_ready,
    output decinfo_t o_decinfo
);

    dec_ctrl_t dec_ctrl;
    word_t     dec_imm;

    // both decoders see the same raw word
    inst_classify u_classify (
        .i_inst (i_inst),
        .o_ctrl (dec_ctrl)
    );

    imm_gen u_imm_gen (
        .i_inst (i_inst),
        .o_imm  (dec_imm)
    );

    // register and handshake
    decinfo_pack u_pack (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .o_inst_ready (o_inst_ready),
        .i_pc         (i_pc),
        .i_ctrl       (dec_ctrl),
        .i_imm        (dec_imm),
        .o_dec_valid  (o_dec_valid),
        .i_dec_ready  (i_dec_ready),
        .o_decinfo    (o_decinfo)
    );

endmodule

//--- decode_stage_asserts.sv
`timescale 1ns/1ps

module decode_stage_asserts import decode_pkg::*; (
    input logic     clk,
    input logic     i_rst_n,
    input logic     i_inst_ready,
    input logic     i_dec_valid,
    input logic     i_dec_ready,
    input decinfo_t i_decinfo
);

    // failures so far, read back at the end of the run
    int fail_count = 0;

    // stalled record must not move
    a_stall_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_dec_valid && !i_dec_ready) |=> (i_dec_valid && $stable(i_decinfo)))
    else begin
        fail_count++;
        $error("output record or valid changed during a stall");
    end

    // nothing leaves while in reset
    a_reset_idle: assert property (@(posedge clk) !i_rst_n |-> !i_dec_valid)
    else begin
        fail_count++;
        $error("output valid high during reset");
    end

    // slot empty, or the held record leaves this edge
    a_ready_rule: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_inst_ready == (!i_dec_valid || i_dec_ready))
    else begin
        fail_count++;
        $error("input ready does not follow the slot state");
    end

endmodule

bind decinfo_pack decode_stage_asserts u_asserts (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_inst_ready (o_inst_ready),
    .i_dec_valid  (o_dec_valid),
    .i_dec_ready  (i_dec_ready),
    .i_decinfo    (o_decinfo)
);

//--- tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    logic     clk = 1'b0;
    logic     i_rst_n;
    logic     i_inst_valid;
    logic     o_inst_ready;
    inst_u    i_inst;
    word_t    i_pc;
    logic     o_dec_valid;
    logic     i_dec_ready;
    decinfo_t o_decinfo;

    // stimulus table as parallel queues indexed by row
    word_t     tbl_inst[$];
    dec_ctrl_t tbl_ctrl[$];
    word_t     tbl_imm[$];

    int          err_count = 0;
    int          timeout_count = 0;
    int unsigned wait_limit = 200;
    logic [31:0] lfsr_state = 32'd71398;

    decode_stage dut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .o_inst_ready (o_inst_ready),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_dec_valid  (o_dec_valid),
        .i_dec_ready  (i_dec_ready),
        .o_decinfo    (o_decinfo)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // instruction encoders take opc as inst[6:2]
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd, logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, logic [4:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc, 2'b11};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, logic [4:0] opc);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc, 2'b11};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [4:0] opc);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd, logic [4:0] opc);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc, 2'b11};
    endfunction

    function automatic word_t row_pc(int k);
        return 32'h0000_1000 + 4 * k;
    endfunction

    // en holds {rd, rs1, rs2}
    // flg holds {rs1topc, rs2toimm, is_nop, illegal}
    task automatic add_row(input word_t w, input fu_e fu, input micop_t op,
                           input logic [2:0] en, input logic [3:0] flg, input word_t imm);
        dec_ctrl_t c;
        c.fu       = fu;
        c.micop    = op;
        // index fields pass through from their fixed slots
        c.rd       = w[11:7];
        c.rs1      = w[19:15];
        c.rs2      = w[24:20];
        {c.rd_en, c.rs1_en, c.rs2_en} = en;
        {c.rs1topc, c.rs2toimm, c.is_nop, c.illegal} = flg;
        tbl_inst.push_back(w);
        tbl_ctrl.push_back(c);
        tbl_imm.push_back(imm);
    endtask

    task automatic check_ctrl(input string name, input dec_ctrl_t exp_v, input dec_ctrl_t act_v);
        if (act_v !== exp_v) begin
            err_count++;
            $display("error: %0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) begin
            err_count++;
            $display("error: %0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            err_count++;
            $display("error: %0t %s expected %b got %b", $time, name, exp_v, act_v);
        end
    endtask

    task automatic build_table();
        // alu register forms
        add_row(enc_r(F7_BASE, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP),
                FU_ALU, MICOP_ADD, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_ALT, 5'd6, 5'd5, 3'd0, 5'd4, OPC_OP),
                FU_ALU, MICOP_SUB, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_ALT, 5'd9, 5'd8, 3'd5, 5'd7, OPC_OP),
                FU_ALU, MICOP_SRA, 3'b111, 4'b0000, '0);
        // rs2 = x0 drops its enable
        add_row(enc_r(F7_BASE, 5'd0, 5'd11, 3'd3, 5'd10, OPC_OP),
                FU_ALU, MICOP_SLTU, 3'b110, 4'b0000, '0);
        // op-imm with a negative addi and shift amounts
        add_row(enc_i(12'hFFB, 5'd2, 3'd0, 5'd1, OPC_OPIMM),
                FU_ALU, MICOP_ADD, 3'b110, 4'b0100, 32'hFFFF_FFFB);
        add_row(enc_i(12'h407, 5'd4, 3'd5, 5'd3, OPC_OPIMM),
                FU_ALU, MICOP_SRA, 3'b110, 4'b0100, 32'd7);
        add_row(enc_i(12'h01F, 5'd6, 3'd1, 5'd5, OPC_OPIMM),
                FU_ALU, MICOP_SLL, 3'b110, 4'b0100, 32'd31);
        // loads and stores
        add_row(enc_i(12'hFFC, 5'd9, 3'd2, 5'd8, OPC_LOAD),
                FU_LDU, MICOP_LW, 3'b110, 4'b0100, 32'hFFFF_FFFC);
        add_row(enc_i(12'h064, 5'd11, 3'd4, 5'd10, OPC_LOAD),
                FU_LDU, MICOP_LBU, 3'b110, 4'b0100, 32'd100);
        add_row(enc_s(12'hFF8, 5'd12, 5'd13, 3'd2, OPC_STORE),
                FU_STU, MICOP_SW, 3'b011, 4'b0100, 32'hFFFF_FFF8);
        // branches keep bit 0 clear
        add_row(enc_b(13'h1FF0, 5'd2, 5'd1, 3'd0, OPC_BRANCH),
                FU_BJU, MICOP_BEQ, 3'b011, 4'b0000, 32'hFFFF_FFF0);
        add_row(enc_b(13'h0FFE, 5'd4, 5'd3, 3'd7, OPC_BRANCH),
                FU_BJU, MICOP_BGEU, 3'b011, 4'b0000, 32'h0000_0FFE);
        // upper immediates and jumps
        add_row(enc_u(20'hABCDE, 5'd5, OPC_LUI),
                FU_ALU, MICOP_LUI, 3'b100, 4'b0100, 32'hABCD_E000);
        add_row(enc_u(20'h12345, 5'd6, OPC_AUIPC),
                FU_ALU, MICOP_ADD, 3'b100, 4'b1100, 32'h1234_5000);
        add_row(enc_j(21'h1F_EFFE, 5'd1, OPC_JAL),
                FU_BJU, MICOP_JAL, 3'b100, 4'b1000, 32'hFFFF_EFFE);
        // rd = x0 leaves only rs1 enabled
        add_row(enc_i(12'h00C, 5'd1, 3'd0, 5'd0, OPC_JALR),
                FU_BJU, MICOP_JALR, 3'b010, 4'b0000, 32'd12);
        // m extension
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP),
                FU_MDU, MICOP_MUL, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd1, 5'd1, OPC_OP),
                FU_MDU, MICOP_MULH, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd2, 5'd1, OPC_OP),
                FU_MDU, MICOP_MULHSU, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd3, 5'd1, OPC_OP),
                FU_MDU, MICOP_MULHU, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd4, 5'd1, OPC_OP),
                FU_MDU, MICOP_DIV, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd5, 5'd1, OPC_OP),
                FU_MDU, MICOP_DIVU, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd6, 5'd1, OPC_OP),
                FU_MDU, MICOP_REM, 3'b111, 4'b0000, '0);
        add_row(enc_r(F7_MULDIV, 5'd3, 5'd2, 3'd7, 5'd1, OPC_OP),
                FU_MDU, MICOP_REMU, 3'b111, 4'b0000, '0);
        // system and fence
        add_row(enc_i(F12_ECALL, 5'd0, 3'd0, 5'd0, OPC_SYSTEM),
                FU_SCU, MICOP_ECALL, 3'b000, 4'b0000, '0);
        add_row(enc_i(F12_EBREAK, 5'd0, 3'd0, 5'd0, OPC_SYSTEM),
                FU_SCU, MICOP_EBREAK, 3'b000, 4'b0000, '0);
        add_row(enc_i(12'h0FF, 5'd0, 3'd0, 5'd0, OPC_FENCE),
                FU_SCU, MICOP_FENCE, 3'b000, 4'b0000, '0);
        add_row(enc_i(12'h300, 5'd17, 3'd5, 5'd5, OPC_SYSTEM),
                FU_SCU, MICOP_CSRRWI, 3'b100, 4'b0000, 32'd17);
        // unknown opcode then a compressed word
        // imm still follows bits 6..2
        add_row(32'h0000_007F,
                FU_NONE, MICOP_ADD, 3'b000, 4'b0001, '0);
        add_row(enc_i(12'h00A, 5'd1, 3'd0, 5'd2, OPC_OPIMM) ^ 32'h2,
                FU_NONE, MICOP_ADD, 3'b000, 4'b0001, 32'd10);
        // addi x5, x5, 0
        add_row(enc_i(12'h000, 5'd5, 3'd0, 5'd5, OPC_OPIMM),
                FU_ALU, MICOP_ADD, 3'b110, 4'b0110, '0);
    endtask

    task automatic drive_rows();
        int unsigned cnt;
        logic        accepted;
        for (int i = 0; i < tbl_inst.size(); i++) begin
            // random idle cycle before the row
            if (rand_bit()) begin
                i_inst_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            i_inst_valid = 1'b1;
            i_inst       = tbl_inst[i];
            i_pc         = row_pc(i);
            cnt      = 0;
            accepted = 1'b0;
            while (!accepted && cnt < wait_limit) begin
                // ready is settled by the falling edge
                @(negedge clk);
                accepted = o_inst_ready;
                cnt++;
                @(posedge clk);
                #1;
            end
            if (!accepted) begin
                timeout_count++;
                $display("timeout: row %0d was never accepted by the stage", i);
                i = tbl_inst.size();
            end
        end
        i_inst_valid = 1'b0;
    endtask

    task automatic collect_rows();
        int          k;
        int unsigned idle;
        k    = 0;
        idle = 0;
        while (k < tbl_inst.size() && idle < wait_limit) begin
            @(posedge clk);
            #1;
            // ready high about three cycles in four
            i_dec_ready = rand_bit() | rand_bit();
            @(negedge clk);
            if (o_dec_valid && i_dec_ready) begin
                check_ctrl($sformatf("o_decinfo.ctrl row %0d", k), tbl_ctrl[k], o_decinfo.ctrl);
                check_word($sformatf("o_decinfo.imm row %0d", k), tbl_imm[k], o_decinfo.imm);
                check_word($sformatf("o_decinfo.pc row %0d", k), row_pc(k), o_decinfo.pc);
                k++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (k < tbl_inst.size()) begin
            timeout_count++;
            $display("timeout: only %0d of %0d records left the stage", k, tbl_inst.size());
        end
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_dec_ready  = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        // idle stage before any input
        @(negedge clk);
        check_bit("o_dec_valid", 1'b0, o_dec_valid);
        check_bit("o_inst_ready", 1'b1, o_inst_ready);
        @(posedge clk);
        #1;
        fork
            drive_rows();
            collect_rows();
        join
        // no extra record after the last one
        @(posedge clk);
        #1;
        i_dec_ready = 1'b1;
        @(negedge clk);
        check_bit("o_dec_valid", 1'b0, o_dec_valid);
        $display("summary: %0d value errors, %0d timeouts, %0d assertion failures",
                 err_count, timeout_count, dut.u_pack.u_asserts.fail_count);
        if (err_count == 0 && timeout_count == 0 && dut.u_pack.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- list.f
decode_pkg.sv
inst_classify.sv
imm_gen.sv
decinfo_pack.sv
decode_stage.sv
decode_stage_asserts.sv
tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_decode_stage

./obj_dir/Vtb_decode_stage +verilator+error+limit+1000 | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
